// ==== decode_stage.f ====
+incdir+source
source/mips_isa_pkg.sv
source/uop_pkg.sv
source/alu_decode.sv
source/branch_decode.sv
source/uop_merge.sv
source/decode_stage.sv
sim/decode_stage_properties.sv
sim/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the decode stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f decode_stage.f \
	--top-module decode_stage_tb \
	&& ./obj_dir/Vdecode_stage_tb | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -q "^Finished with no errors$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== sim/decode_stage_properties.sv ====
module decode_stage_properties
(
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input logic uop_valid,
	input logic has_delay_slot,
	input logic has_nullifying_delay_slot,
	input logic is_br,
	input uop_pkg::uop_op_t uop_op
);
	timeunit 1ns;
	timeprecision 1ps;
	import uop_pkg::*;

	a_reset_clears_valid: assert property (@(posedge clk) rst |=> !uop_valid)
		else $error("uop_valid high in the cycle after reset");

	// one cycle latency, no stall
	a_valid_follows_input: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (uop_valid == $past(insn_valid)))
		else $error("uop_valid does not follow insn_valid by one cycle");

	a_nullify_has_slot: assert property (@(posedge clk)
		(uop_valid && has_nullifying_delay_slot) |-> has_delay_slot)
		else $error("nullifying delay slot without a delay slot");

	a_branch_not_alu: assert property (@(posedge clk)
		(uop_valid && is_br) |-> !(uop_op inside {[SLL:MOVI]}))
		else $error("branch flag set on an alu opcode");

endmodule

bind decode_stage decode_stage_properties u_props
(
	.clk(clk),
	.rst(rst),
	.insn_valid(insn_valid),
	.uop_valid(uop_valid),
	.has_delay_slot(has_delay_slot),
	.has_nullifying_delay_slot(has_nullifying_delay_slot),
	.is_br(is_br),
	.uop_op(uop_op)
);

// ==== sim/decode_stage_tb.sv ====
`include "mips_defines.svh"

module decode_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_isa_pkg::*;
	import uop_pkg::*;

	logic clk;
	logic rst;
	logic insn_valid;
	logic [31:0] insn;
	logic [`M_WIDTH-1:0] pc;
	logic insn_pred;
	logic [`LG_PHT_SZ-1:0] pht_idx;
	logic uop_valid;
	uop_op_t uop_op;
	preg_t src_a;
	logic src_a_valid;
	preg_t src_b;
	logic src_b_valid;
	preg_t dst;
	logic dst_valid;
	logic [15:0] imm;
	logic [`M_WIDTH-17:0] jmp_imm;
	logic has_delay_slot;
	logic has_nullifying_delay_slot;
	logic br_pred;
	logic is_br;
	logic [`M_WIDTH-1:0] uop_pc;
	logic [`LG_PHT_SZ-1:0] uop_pht_idx;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	decode_stage u_dut
	(
		.clk(clk),
		.rst(rst),
		.insn_valid(insn_valid),
		.insn(insn),
		.pc(pc),
		.insn_pred(insn_pred),
		.pht_idx(pht_idx),
		.uop_valid(uop_valid),
		.uop_op(uop_op),
		.src_a(src_a),
		.src_a_valid(src_a_valid),
		.src_b(src_b),
		.src_b_valid(src_b_valid),
		.dst(dst),
		.dst_valid(dst_valid),
		.imm(imm),
		.jmp_imm(jmp_imm),
		.has_delay_slot(has_delay_slot),
		.has_nullifying_delay_slot(has_nullifying_delay_slot),
		.br_pred(br_pred),
		.is_br(is_br),
		.uop_pc(uop_pc),
		.uop_pht_idx(uop_pht_idx)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= 400)
		begin
			$display("timeout: tests did not finish within 400 cycles");
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
		end
	endtask

	function automatic preg_t to_preg(input logic [4:0] r);
		to_preg = {{(`LG_PRF_ENTRIES - 5){1'b0}}, r};
	endfunction

	function automatic logic [4:0] rand_reg(); // never register 0
		logic [31:0] r;
		r = $urandom();
		rand_reg = 5'(r % 32'd31) + 5'd1;
	endfunction

	function automatic logic [15:0] rand_half();
		logic [31:0] r;
		r = $urandom();
		rand_half = r[15:0];
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = $urandom();
		rand_bit = r[0];
	endfunction

	function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input mips_funct_t fn);
		rtype = {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] itype(input mips_opcode_t op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] im);
		itype = {op, rs, rt, im};
	endfunction

	// one word in for a single cycle
	task automatic issue(input logic [31:0] word, input logic pred);
		logic [31:0] r;
		@(negedge clk);
		r = $urandom();
		insn_valid = 1'b1;
		insn = word;
		insn_pred = pred;
		pc = {r[31:2], 2'b00};
		pht_idx = r[`LG_PHT_SZ+1:2];
		@(negedge clk);
		insn_valid = 1'b0;
	endtask

	task automatic check_uop(input uop_op_t e_op, input preg_t e_sa, input logic e_sav,
		input preg_t e_sb, input logic e_sbv, input preg_t e_dst, input logic e_dv,
		input logic [15:0] e_imm, input logic [`M_WIDTH-17:0] e_jmp, input logic e_ds,
		input logic e_nds, input logic e_pred, input logic e_br);
		check_field("uop_valid", 32'd1, 32'(uop_valid));
		check_field("uop_op", 32'(e_op), 32'(uop_op));
		check_field("src_a", 32'(e_sa), 32'(src_a));
		check_field("src_a_valid", 32'(e_sav), 32'(src_a_valid));
		check_field("src_b", 32'(e_sb), 32'(src_b));
		check_field("src_b_valid", 32'(e_sbv), 32'(src_b_valid));
		check_field("dst", 32'(e_dst), 32'(dst));
		check_field("dst_valid", 32'(e_dv), 32'(dst_valid));
		check_field("imm", 32'(e_imm), 32'(imm));
		check_field("jmp_imm", 32'(e_jmp), 32'(jmp_imm));
		check_field("has_delay_slot", 32'(e_ds), 32'(has_delay_slot));
		check_field("has_nullifying_delay_slot", 32'(e_nds), 32'(has_nullifying_delay_slot));
		check_field("br_pred", 32'(e_pred), 32'(br_pred));
		check_field("is_br", 32'(e_br), 32'(is_br));
	endtask

	task automatic test_reset();
		repeat (5)
		begin
			@(negedge clk);
			check_field("uop_valid", 32'd0, 32'(uop_valid));
		end
		rst = 1'b0;
		repeat (3)
		begin
			@(negedge clk);
			check_field("uop_valid", 32'd0, 32'(uop_valid)); // insn_valid still low
		end
	endtask

	task automatic test_rtype();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		mips_funct_t fns [6] = '{FN_ADDU, FN_SUBU, FN_OR, FN_SLT, FN_SLLV, FN_SRA};
		rs = rand_reg();
		rt = rand_reg();
		while (rt == rs)
			rt = rand_reg();
		rd = rand_reg();
		while (rd == rs || rd == rt)
			rd = rand_reg();
		sa = rand_reg();
		issue(rtype(rs, rt, rd, 5'd0, FN_ADDU), 1'b0);
		check_uop(ADDU, to_preg(rt), 1'b1, to_preg(rs), 1'b1, to_preg(rd), 1'b1,
			16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(rtype(rs, rt, rd, 5'd0, FN_SUBU), 1'b0);
		check_uop(SUBU, to_preg(rs), 1'b1, to_preg(rt), 1'b1, to_preg(rd), 1'b1,
			16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0); // operands swapped
		issue(rtype(rs, rt, rd, 5'd0, FN_OR), 1'b0);
		check_uop(OR, to_preg(rt), 1'b1, to_preg(rs), 1'b1, to_preg(rd), 1'b1,
			16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(rtype(rs, rt, rd, 5'd0, FN_SLT), 1'b0);
		check_uop(SLT, to_preg(rt), 1'b1, to_preg(rs), 1'b1, to_preg(rd), 1'b1,
			16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(rtype(rs, rt, rd, 5'd0, FN_SLLV), 1'b0);
		check_uop(SLLV, to_preg(rt), 1'b1, to_preg(rs), 1'b1, to_preg(rd), 1'b1,
			16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(rtype(5'd0, rt, rd, sa, FN_SRA), 1'b0);
		check_uop(SRA, to_preg(rt), 1'b1, to_preg(sa), 1'b0, to_preg(rd), 1'b1,
			16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0); // shamt carried without a read
		foreach (fns[i])
		begin
			issue(rtype(rs, rt, 5'd0, 5'd0, fns[i]), 1'b0);
			check_field("uop_op", 32'(NOP), 32'(uop_op));
			check_field("dst_valid", 32'd0, 32'(dst_valid));
		end
		issue(rtype(5'd0, rt, rd, 5'd0, FN_OR), 1'b0);
		check_uop(MOV, to_preg(rt), 1'b1, '0, 1'b0, to_preg(rd), 1'b1,
			16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(32'd0, 1'b0);
		check_field("uop_op", 32'(NOP), 32'(uop_op));
		check_field("dst_valid", 32'd0, 32'(dst_valid));
	endtask

	task automatic test_imm();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] im;
		rs = rand_reg();
		rt = rand_reg();
		while (rt == rs)
			rt = rand_reg();
		im = rand_half();
		issue(itype(OP_ORI, rs, rt, im), 1'b0);
		check_uop(ORI, to_preg(rs), 1'b1, '0, 1'b0, to_preg(rt), 1'b1,
			im, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(itype(OP_SLTIU, rs, rt, im), 1'b0);
		check_uop(SLTIU, to_preg(rs), 1'b1, '0, 1'b0, to_preg(rt), 1'b1,
			im, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(itype(OP_ADDIU, rs, rt, im), 1'b0);
		check_uop(ADDIU, to_preg(rs), 1'b1, '0, 1'b0, to_preg(rt), 1'b1,
			im, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(itype(OP_LUI, 5'd0, rt, im), 1'b0);
		check_uop(LUI, '0, 1'b0, '0, 1'b0, to_preg(rt), 1'b1,
			im, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(itype(OP_ADDIU, 5'd0, rt, im), 1'b0);
		check_uop(MOVI, '0, 1'b0, '0, 1'b0, to_preg(rt), 1'b1,
			im, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(itype(OP_ADDIU, rs, 5'd0, im), 1'b0);
		check_field("uop_op", 32'(NOP), 32'(uop_op));
		check_field("dst_valid", 32'd0, 32'(dst_valid));
	endtask

	task automatic test_branch();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] off;
		logic pred;
		logic [25:0] tgt;
		logic [`M_WIDTH-17:0] e_jmp;
		preg_t link;
		rs = rand_reg();
		rt = rand_reg();
		while (rt == rs)
			rt = rand_reg();
		off = rand_half();
		link = to_preg(5'd31);
		pred = rand_bit();
		issue(itype(OP_BEQ, rs, rt, off), pred);
		check_uop(BEQ, to_preg(rs), 1'b1, to_preg(rt), 1'b1, '0, 1'b0,
			off, '0, 1'b1, 1'b0, pred, 1'b1);
		pred = rand_bit();
		issue(itype(OP_BNEL, rs, rt, off), pred);
		check_uop(BNEL, to_preg(rs), 1'b1, to_preg(rt), 1'b1, '0, 1'b0,
			off, '0, 1'b1, 1'b1, pred, 1'b1);
		pred = rand_bit();
		issue(itype(OP_BGTZ, rs, 5'd0, off), pred);
		check_uop(BGTZ, to_preg(rs), 1'b1, '0, 1'b0, '0, 1'b0,
			off, '0, 1'b1, 1'b0, pred, 1'b1);
		pred = rand_bit();
		issue(itype(OP_REGIMM, rs, RI_BLTZL, off), pred);
		check_uop(BLTZL, to_preg(rs), 1'b1, '0, 1'b0, '0, 1'b0,
			off, '0, 1'b1, 1'b1, pred, 1'b1);
		pred = rand_bit();
		issue(itype(OP_REGIMM, rs, RI_BGEZAL, off), pred);
		check_uop(BGEZAL, to_preg(rs), 1'b1, link, 1'b1, link, 1'b1,
			off, '0, 1'b1, 1'b0, pred, 1'b1); // link register read and written
		issue(itype(OP_REGIMM, 5'd0, RI_BGEZAL, off), pred);
		check_field("uop_op", 32'(BAL), 32'(uop_op));
		check_field("src_b_valid", 32'd0, 32'(src_b_valid));
		check_field("dst", 32'(link), 32'(dst));
		check_field("dst_valid", 32'd1, 32'(dst_valid));
		check_field("is_br", 32'd1, 32'(is_br));
		tgt = {rs, rt, off};
		e_jmp = '0;
		e_jmp[9:0] = {rs, rt}; // target bits 25..16 land in the low bits
		issue({OP_JAL, tgt}, 1'b0);
		check_uop(JAL, '0, 1'b0, '0, 1'b0, link, 1'b1, off,
			e_jmp, 1'b1, 1'b0, 1'b1, 1'b1);
		issue(rtype(rs, 5'd0, 5'd0, 5'd0, FN_JALR), 1'b0);
		check_field("uop_op", 32'(JALR), 32'(uop_op));
		check_field("src_a", 32'(to_preg(rs)), 32'(src_a));
		check_field("src_a_valid", 32'd1, 32'(src_a_valid));
		check_field("dst_valid", 32'd0, 32'(dst_valid));
		check_field("imm", 32'd0, 32'(imm));
		check_field("has_delay_slot", 32'd1, 32'(has_delay_slot));
		check_field("is_br", 32'd1, 32'(is_br));
	endtask

	task automatic test_illegal();
		logic [4:0] rs;
		rs = rand_reg();
		issue({6'd8, rs, rand_reg(), rand_half()}, 1'b1); // addi is not decoded
		check_uop(II, '0, 1'b0, '0, 1'b0, '0, 1'b0, 16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		issue(itype(OP_REGIMM, rs, 5'd4, rand_half()), 1'b1);
		check_uop(II, '0, 1'b0, '0, 1'b0, '0, 1'b0, 16'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_stream();
		logic [31:0] r;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] off;
		logic pred;
		logic was_valid;
		uop_op_t e_op;
		preg_t e_dst;
		logic e_dv;
		logic [15:0] e_imm;
		logic e_pred;
		logic e_br;
		logic [`M_WIDTH-1:0] e_pc;
		logic [`LG_PHT_SZ-1:0] e_pht;
		was_valid = 1'b0;
		for (int i = 0; i <= 21; i++)
		begin
			@(negedge clk);
			check_field("uop_valid", 32'(was_valid), 32'(uop_valid));
			if (i > 0)
			begin
				// after the bubble these still hold the last word
				check_field("uop_op", 32'(e_op), 32'(uop_op));
				check_field("dst", 32'(e_dst), 32'(dst));
				check_field("dst_valid", 32'(e_dv), 32'(dst_valid));
				check_field("imm", 32'(e_imm), 32'(imm));
				check_field("br_pred", 32'(e_pred), 32'(br_pred));
				check_field("is_br", 32'(e_br), 32'(is_br));
				check_field("uop_pc", e_pc, uop_pc);
				check_field("uop_pht_idx", 32'(e_pht), 32'(uop_pht_idx));
			end
			if (i == 10 || i == 21)
			begin
				insn_valid = 1'b0;
				insn = ~insn; // would decode differently if captured
				pc = ~e_pc;
				pht_idx = ~e_pht;
				was_valid = 1'b0;
			end
			else
			begin
				rs = rand_reg();
				rt = rand_reg();
				rd = rand_reg();
				off = rand_half();
				pred = rand_bit();
				r = $urandom();
				e_pc = {r[31:2], 2'b00};
				r = $urandom();
				e_pht = r[`LG_PHT_SZ-1:0];
				if (r[16])
				begin
					insn = rtype(rs, rt, rd, 5'd0, FN_ADDU);
					e_op = ADDU;
					e_dst = to_preg(rd);
					e_dv = 1'b1;
					e_imm = 16'd0;
					e_pred = 1'b0;
					e_br = 1'b0;
				end
				else
				begin
					insn = itype(OP_BNE, rs, rt, off);
					e_op = BNE;
					e_dst = '0;
					e_dv = 1'b0;
					e_imm = off;
					e_pred = pred;
					e_br = 1'b1;
				end
				insn_valid = 1'b1;
				insn_pred = pred;
				pc = e_pc;
				pht_idx = e_pht;
				was_valid = 1'b1;
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'h78d6));
		rst = 1'b1;
		insn_valid = 1'b0;
		insn = 32'd0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		test_reset();
		test_rtype();
		test_imm();
		test_branch();
		test_illegal();
		test_stream();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== source/alu_decode.sv ====
`include "mips_defines.svh"

module alu_decode
(
	input logic [31:0] insn,
	output logic hit,
	output uop_pkg::uop_op_t op,
	output uop_pkg::preg_t src_a,
	output uop_pkg::preg_t src_b,
	output uop_pkg::preg_t dst,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic dst_valid,
	output logic [15:0] imm
);
	import mips_isa_pkg::*;
	import uop_pkg::*;

	localparam ZP = `LG_PRF_ENTRIES - 5;

	mips_opcode_t opcode;
	mips_funct_t funct;
	preg_t rs;
	preg_t rt;
	preg_t rd;
	preg_t shamt;
	logic imm_only;

	assign opcode = mips_opcode_t'(insn[31:26]);
	assign funct = mips_funct_t'(insn[5:0]);
	assign rs = {{ZP{1'b0}}, insn[25:21]};
	assign rt = {{ZP{1'b0}}, insn[20:16]};
	assign rd = {{ZP{1'b0}}, insn[15:11]};
	assign shamt = {{ZP{1'b0}}, insn[10:6]};
	assign imm_only = (opcode == OP_LUI) || (opcode == OP_ADDIU && rs == '0); // lui and movi

	function automatic uop_op_t rtype_op(input mips_funct_t f, input logic rs_zero);
		case (f)
			FN_SLL: rtype_op = SLL;
			FN_SRL: rtype_op = SRL;
			FN_SRA: rtype_op = SRA;
			FN_SLLV: rtype_op = SLLV;
			FN_SRLV: rtype_op = SRLV;
			FN_SRAV: rtype_op = SRAV;
			FN_ADDU: rtype_op = ADDU;
			FN_SUBU: rtype_op = SUBU;
			FN_AND: rtype_op = AND;
			FN_OR: rtype_op = rs_zero ? MOV : OR; // or with $0 is a move
			FN_XOR: rtype_op = XOR;
			FN_NOR: rtype_op = NOR;
			FN_SLT: rtype_op = SLT;
			FN_SLTU: rtype_op = SLTU;
			default: rtype_op = II;
		endcase
	endfunction

	function automatic uop_op_t itype_op(input mips_opcode_t o, input logic rs_zero);
		case (o)
			OP_ADDIU: itype_op = rs_zero ? MOVI : ADDIU;
			OP_SLTI: itype_op = SLTI;
			OP_SLTIU: itype_op = SLTIU;
			OP_ANDI: itype_op = ANDI;
			OP_ORI: itype_op = ORI;
			OP_XORI: itype_op = XORI;
			OP_LUI: itype_op = LUI;
			default: itype_op = II;
		endcase
	endfunction

	always_comb
	begin
		hit = 1'b0;
		op = II;
		src_a = '0;
		src_a_valid = 1'b0;
		src_b = '0;
		src_b_valid = 1'b0;
		dst = '0;
		dst_valid = 1'b0;
		imm = 16'd0;
		case (opcode)
			OP_SPECIAL:
			begin
				case (funct)
					FN_SLL, FN_SRL, FN_SRA:
					begin
						hit = 1'b1;
						src_a = rt;
						src_a_valid = 1'b1;
						src_b = shamt; // constant amount, no read
						dst = rd;
						dst_valid = (rd != '0);
						op = (rd == '0) ? NOP : rtype_op(funct, 1'b0); // covers all-zero word
					end
					FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU, FN_AND, FN_OR,
					FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
					begin
						hit = 1'b1;
						src_a = (funct == FN_SUBU) ? rs : rt; // subu keeps rs first
						src_a_valid = 1'b1;
						src_b = (funct == FN_SUBU) ? rt : rs;
						src_b_valid = !(funct == FN_OR && rs == '0);
						dst = rd;
						dst_valid = (rd != '0);
						op = (rd == '0) ? NOP : rtype_op(funct, rs == '0);
					end
					FN_SYNC, FN_TEQ:
					begin
						hit = 1'b1;
						op = NOP;
					end
					default:
					begin
					end
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			begin
				hit = 1'b1;
				src_a = imm_only ? '0 : rs;
				src_a_valid = !imm_only;
				dst = rt;
				dst_valid = (rt != '0);
				imm = insn[15:0];
				op = (rt == '0) ? NOP : itype_op(opcode, rs == '0);
			end
			OP_PREF:
			begin
				hit = 1'b1;
				op = NOP; // prefetch hint dropped
			end
			default:
			begin
			end
		endcase
	end

endmodule

// ==== source/branch_decode.sv ====
`include "mips_defines.svh"

module branch_decode
(
	input logic [31:0] insn,
	input logic insn_pred,
	output logic hit,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic dst_valid,
	output logic has_delay_slot,
	output logic has_nullifying_delay_slot,
	output logic br_pred,
	output uop_pkg::uop_op_t op,
	output uop_pkg::preg_t src_a,
	output uop_pkg::preg_t src_b,
	output uop_pkg::preg_t dst,
	output logic [15:0] imm,
	output logic [`M_WIDTH-17:0] jmp_imm
);
	import mips_isa_pkg::*;
	import uop_pkg::*;

	localparam ZP = `LG_PRF_ENTRIES - 5;
	localparam preg_t LINK_REG = 'd31;

	mips_opcode_t opcode;
	mips_regimm_t regimm;
	preg_t rs;
	preg_t rt;
	preg_t rd;
	logic rs_zero;
	logic two_src;
	logic likely_op;

	assign opcode = mips_opcode_t'(insn[31:26]);
	assign regimm = mips_regimm_t'(insn[20:16]);
	assign rs = {{ZP{1'b0}}, insn[25:21]};
	assign rt = {{ZP{1'b0}}, insn[20:16]};
	assign rd = {{ZP{1'b0}}, insn[15:11]};
	assign rs_zero = (rs == '0);
	assign two_src = opcode inside {OP_BEQ, OP_BNE, OP_BEQL, OP_BNEL};
	assign likely_op = opcode inside {OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL};

	always_comb
	begin
		hit = 1'b0;
		op = II;
		src_a = '0;
		src_a_valid = 1'b0;
		src_b = '0;
		src_b_valid = 1'b0;
		dst = '0;
		dst_valid = 1'b0;
		imm = 16'd0;
		jmp_imm = '0;
		br_pred = 1'b0;
		has_nullifying_delay_slot = 1'b0;
		case (opcode)
			OP_BEQ, OP_BNE, OP_BEQL, OP_BNEL, OP_BLEZ, OP_BGTZ, OP_BLEZL, OP_BGTZL:
			begin
				hit = 1'b1;
				case (opcode)
					OP_BEQ: op = BEQ;
					OP_BNE: op = BNE;
					OP_BLEZ: op = BLEZ;
					OP_BGTZ: op = BGTZ;
					OP_BEQL: op = BEQL;
					OP_BNEL: op = BNEL;
					OP_BLEZL: op = BLEZL;
					default: op = BGTZL;
				endcase
				src_a = rs;
				src_a_valid = 1'b1;
				src_b = two_src ? rt : '0; // blez/bgtz compare against zero
				src_b_valid = two_src;
				imm = insn[15:0];
				br_pred = insn_pred;
				has_nullifying_delay_slot = likely_op;
			end
			OP_REGIMM:
			begin
				hit = 1'b1;
				src_a = rs;
				src_a_valid = 1'b1;
				imm = insn[15:0];
				br_pred = insn_pred;
				case (regimm)
					RI_BLTZ: op = BLTZ;
					RI_BGEZ: op = BGEZ;
					RI_BLTZL:
					begin
						op = BLTZL;
						has_nullifying_delay_slot = 1'b1;
					end
					RI_BGEZL:
					begin
						op = BGEZL;
						has_nullifying_delay_slot = 1'b1;
					end
					RI_BGEZAL:
					begin
						op = rs_zero ? BAL : BGEZAL; // always taken on $0
						dst = LINK_REG;
						dst_valid = 1'b1;
						src_b = LINK_REG;
						src_b_valid = !rs_zero;
					end
					default: hit = 1'b0;
				endcase
			end
			OP_J:
			begin
				hit = 1'b1;
				op = J;
			end
			OP_JAL:
			begin
				hit = 1'b1;
				op = JAL;
				dst = LINK_REG;
				dst_valid = 1'b1;
				imm = insn[15:0];
				jmp_imm = {{(`M_WIDTH - 26){1'b0}}, insn[25:16]}; // upper target bits
				br_pred = 1'b1;
			end
			OP_SPECIAL:
			begin
				if (insn[5:0] == FN_JR || insn[5:0] == FN_JALR)
				begin
					hit = 1'b1;
					op = (insn[5:0] == FN_JR) ? JR : JALR;
					src_a = rs;
					src_a_valid = 1'b1;
					dst = (insn[5:0] == FN_JALR) ? rd : '0;
					dst_valid = (insn[5:0] == FN_JALR) && (rd != '0);
				end
			end
			default:
			begin
			end
		endcase
		has_delay_slot = hit; // every branch and jump has one
	end

endmodule

// ==== source/decode_stage.sv ====
`include "mips_defines.svh"

module decode_stage
(
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input logic [31:0] insn,
	input logic [`M_WIDTH-1:0] pc,
	input logic insn_pred,
	input logic [`LG_PHT_SZ-1:0] pht_idx,
	output logic uop_valid,
	output uop_pkg::uop_op_t uop_op,
	output uop_pkg::preg_t src_a,
	output logic src_a_valid,
	output uop_pkg::preg_t src_b,
	output logic src_b_valid,
	output uop_pkg::preg_t dst,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic [`M_WIDTH-17:0] jmp_imm,
	output logic has_delay_slot,
	output logic has_nullifying_delay_slot,
	output logic br_pred,
	output logic is_br,
	output logic [`M_WIDTH-1:0] uop_pc,
	output logic [`LG_PHT_SZ-1:0] uop_pht_idx
);
	import uop_pkg::*;

	logic alu_hit;
	uop_op_t alu_op;
	preg_t alu_src_a;
	preg_t alu_src_b;
	preg_t alu_dst;
	logic alu_src_a_valid;
	logic alu_src_b_valid;
	logic alu_dst_valid;
	logic [15:0] alu_imm;

	logic br_hit;
	uop_op_t br_op;
	preg_t br_src_a;
	preg_t br_src_b;
	preg_t br_dst;
	logic br_src_a_valid;
	logic br_src_b_valid;
	logic br_dst_valid;
	logic [15:0] br_imm;
	logic [`M_WIDTH-17:0] br_jmp_imm;
	logic br_has_delay_slot;
	logic br_has_nullifying_delay_slot;
	logic br_br_pred;

	alu_decode u_alu_decode
	(
		.insn(insn),
		.hit(alu_hit),
		.op(alu_op),
		.src_a(alu_src_a),
		.src_b(alu_src_b),
		.dst(alu_dst),
		.src_a_valid(alu_src_a_valid),
		.src_b_valid(alu_src_b_valid),
		.dst_valid(alu_dst_valid),
		.imm(alu_imm)
	);

	branch_decode u_branch_decode
	(
		.insn(insn),
		.insn_pred(insn_pred),
		.hit(br_hit),
		.src_a_valid(br_src_a_valid),
		.src_b_valid(br_src_b_valid),
		.dst_valid(br_dst_valid),
		.has_delay_slot(br_has_delay_slot),
		.has_nullifying_delay_slot(br_has_nullifying_delay_slot),
		.br_pred(br_br_pred),
		.op(br_op),
		.src_a(br_src_a),
		.src_b(br_src_b),
		.dst(br_dst),
		.imm(br_imm),
		.jmp_imm(br_jmp_imm)
	);

	// decoders claim disjoint opcodes, merge only looks at the hits
	uop_merge u_uop_merge
	(
		.clk(clk),
		.rst(rst),
		.insn_valid(insn_valid),
		.alu_hit(alu_hit),
		.alu_op(alu_op),
		.alu_src_a(alu_src_a),
		.alu_src_a_valid(alu_src_a_valid),
		.alu_src_b(alu_src_b),
		.alu_src_b_valid(alu_src_b_valid),
		.alu_dst(alu_dst),
		.alu_dst_valid(alu_dst_valid),
		.alu_imm(alu_imm),
		.br_hit(br_hit),
		.br_op(br_op),
		.br_src_a(br_src_a),
		.br_src_a_valid(br_src_a_valid),
		.br_src_b(br_src_b),
		.br_src_b_valid(br_src_b_valid),
		.br_dst(br_dst),
		.br_dst_valid(br_dst_valid),
		.br_imm(br_imm),
		.br_jmp_imm(br_jmp_imm),
		.br_has_delay_slot(br_has_delay_slot),
		.br_has_nullifying_delay_slot(br_has_nullifying_delay_slot),
		.br_br_pred(br_br_pred),
		.pc(pc),
		.pht_idx(pht_idx),
		.uop_valid(uop_valid),
		.uop_op(uop_op),
		.src_a(src_a),
		.src_a_valid(src_a_valid),
		.src_b(src_b),
		.src_b_valid(src_b_valid),
		.dst(dst),
		.dst_valid(dst_valid),
		.imm(imm),
		.jmp_imm(jmp_imm),
		.has_delay_slot(has_delay_slot),
		.has_nullifying_delay_slot(has_nullifying_delay_slot),
		.br_pred(br_pred),
		.is_br(is_br),
		.uop_pc(uop_pc),
		.uop_pht_idx(uop_pht_idx)
	);

endmodule

// ==== source/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// machine address width
`define M_WIDTH 32

// register specifier width in the micro-op, arch fields are zero padded
`define LG_PRF_ENTRIES 6

// pattern history table index width
`define LG_PHT_SZ 8

`endif

// ==== source/mips_isa_pkg.sv ====
package mips_isa_pkg;

	typedef enum logic [5:0]
	{
		OP_SPECIAL = 6'd0,
		OP_REGIMM  = 6'd1,
		OP_J       = 6'd2,
		OP_JAL     = 6'd3,
		OP_BEQ     = 6'd4,
		OP_BNE     = 6'd5,
		OP_BLEZ    = 6'd6,
		OP_BGTZ    = 6'd7,
		OP_ADDIU   = 6'd9,
		OP_SLTI    = 6'd10,
		OP_SLTIU   = 6'd11,
		OP_ANDI    = 6'd12,
		OP_ORI     = 6'd13,
		OP_XORI    = 6'd14,
		OP_LUI     = 6'd15,
		OP_BEQL    = 6'd20,
		OP_BNEL    = 6'd21,
		OP_BLEZL   = 6'd22,
		OP_BGTZL   = 6'd23,
		OP_PREF    = 6'd51
	} mips_opcode_t;

	typedef enum logic [5:0]
	{
		FN_SLL  = 6'd0,
		FN_SRL  = 6'd2,
		FN_SRA  = 6'd3,
		FN_SLLV = 6'd4,
		FN_SRLV = 6'd6,
		FN_SRAV = 6'd7,
		FN_JR   = 6'd8,
		FN_JALR = 6'd9,
		FN_SYNC = 6'd15,
		FN_ADDU = 6'd33,
		FN_SUBU = 6'd35,
		FN_AND  = 6'd36,
		FN_OR   = 6'd37,
		FN_XOR  = 6'd38,
		FN_NOR  = 6'd39,
		FN_SLT  = 6'd42,
		FN_SLTU = 6'd43,
		FN_TEQ  = 6'd52
	} mips_funct_t;

	// rt field codes under REGIMM
	typedef enum logic [4:0]
	{
		RI_BLTZ   = 5'd0,
		RI_BGEZ   = 5'd1,
		RI_BLTZL  = 5'd2,
		RI_BGEZL  = 5'd3,
		RI_BGEZAL = 5'd17
	} mips_regimm_t;

endpackage

// ==== source/uop_merge.sv ====
`include "mips_defines.svh"

module uop_merge
(
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input logic alu_hit,
	input uop_pkg::uop_op_t alu_op,
	input uop_pkg::preg_t alu_src_a,
	input logic alu_src_a_valid,
	input uop_pkg::preg_t alu_src_b,
	input logic alu_src_b_valid,
	input uop_pkg::preg_t alu_dst,
	input logic alu_dst_valid,
	input logic [15:0] alu_imm,
	input logic br_hit,
	input uop_pkg::uop_op_t br_op,
	input uop_pkg::preg_t br_src_a,
	input logic br_src_a_valid,
	input uop_pkg::preg_t br_src_b,
	input logic br_src_b_valid,
	input uop_pkg::preg_t br_dst,
	input logic br_dst_valid,
	input logic [15:0] br_imm,
	input logic [`M_WIDTH-17:0] br_jmp_imm,
	input logic br_has_delay_slot,
	input logic br_has_nullifying_delay_slot,
	input logic br_br_pred,
	input logic [`M_WIDTH-1:0] pc,
	input logic [`LG_PHT_SZ-1:0] pht_idx,
	output logic uop_valid,
	output uop_pkg::uop_op_t uop_op,
	output uop_pkg::preg_t src_a,
	output logic src_a_valid,
	output uop_pkg::preg_t src_b,
	output logic src_b_valid,
	output uop_pkg::preg_t dst,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic [`M_WIDTH-17:0] jmp_imm,
	output logic has_delay_slot,
	output logic has_nullifying_delay_slot,
	output logic br_pred,
	output logic is_br,
	output logic [`M_WIDTH-1:0] uop_pc,
	output logic [`LG_PHT_SZ-1:0] uop_pht_idx
);
	import uop_pkg::*;

	uop_op_t n_op;
	preg_t n_src_a;
	preg_t n_src_b;
	preg_t n_dst;
	logic n_src_a_valid;
	logic n_src_b_valid;
	logic n_dst_valid;
	logic [15:0] n_imm;
	logic [`M_WIDTH-17:0] n_jmp_imm;
	logic n_delay;
	logic n_nullify;
	logic n_pred;
	logic n_is_br;

	always_comb
	begin
		n_op = II; // neither decoder claimed the word
		n_src_a = '0;
		n_src_b = '0;
		n_dst = '0;
		n_src_a_valid = 1'b0;
		n_src_b_valid = 1'b0;
		n_dst_valid = 1'b0;
		n_imm = 16'd0;
		n_jmp_imm = '0;
		n_delay = 1'b0;
		n_nullify = 1'b0;
		n_pred = 1'b0;
		n_is_br = 1'b0;
		if (alu_hit)
		begin
			n_op = alu_op;
			n_src_a = alu_src_a;
			n_src_b = alu_src_b;
			n_dst = alu_dst;
			n_src_a_valid = alu_src_a_valid;
			n_src_b_valid = alu_src_b_valid;
			n_dst_valid = alu_dst_valid;
			n_imm = alu_imm;
		end
		else if (br_hit)
		begin
			n_op = br_op;
			n_src_a = br_src_a;
			n_src_b = br_src_b;
			n_dst = br_dst;
			n_src_a_valid = br_src_a_valid;
			n_src_b_valid = br_src_b_valid;
			n_dst_valid = br_dst_valid;
			n_imm = br_imm;
			n_jmp_imm = br_jmp_imm;
			n_delay = br_has_delay_slot;
			n_nullify = br_has_nullifying_delay_slot;
			n_pred = br_br_pred;
			n_is_br = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			uop_valid <= 1'b0;
		else
			uop_valid <= insn_valid;
	end

	// payload holds while no instruction enters
	always_ff @(posedge clk)
	begin
		if (insn_valid)
		begin
			uop_op <= n_op;
			src_a <= n_src_a;
			src_a_valid <= n_src_a_valid;
			src_b <= n_src_b;
			src_b_valid <= n_src_b_valid;
			dst <= n_dst;
			dst_valid <= n_dst_valid;
			imm <= n_imm;
			jmp_imm <= n_jmp_imm;
			has_delay_slot <= n_delay;
			has_nullifying_delay_slot <= n_nullify;
			br_pred <= n_pred;
			is_br <= n_is_br;
			uop_pc <= pc;
			uop_pht_idx <= pht_idx;
		end
	end

endmodule

// ==== source/uop_pkg.sv ====
`include "mips_defines.svh"

package uop_pkg;

	typedef logic [`LG_PRF_ENTRIES-1:0] preg_t;

	typedef enum logic [5:0]
	{
		// integer alu
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		ADDU, SUBU, AND, OR, XOR, NOR,
		SLT, SLTU, MOV,
		ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI, MOVI,
		// conditional branches
		BEQ, BNE, BLEZ, BGTZ,
		BEQL, BNEL, BLEZL, BGTZL,
		BLTZ, BGEZ, BLTZL, BGEZL,
		BGEZAL, BAL,
		// jumps
		J, JAL, JR, JALR,
		NOP,
		II // illegal instruction
	} uop_op_t;

endpackage
